//--- rtl/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// reservation station depth
`define EXEC_ENTRIES 4

// rob tag width, eight rob slots
`define EXEC_TAG_BITS 3

// integer data width
`define EXEC_XLEN 32

`endif

//--- rtl/exec_pkg.sv
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

	// funct3 encoding, slt/sltu slots reused for sra and sub
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_op_e;

	// branch funct3 encoding
	typedef enum logic [2:0] {
		cmp_beq  = 3'b000,
		cmp_bne  = 3'b001,
		cmp_blt  = 3'b100,
		cmp_bge  = 3'b101,
		cmp_bltu = 3'b110,
		cmp_bgeu = 3'b111
	} cmp_op_e;

	// major opcodes handled by the integer cluster
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} opcode_e;

	// decoded instruction from dispatch
	// a busy source carries its producer tag in the low bits of the value
	typedef struct packed {
		logic [`EXEC_TAG_BITS-1:0] tag;
		opcode_e                   opcode;
		logic [2:0]                funct3;
		logic [6:0]                funct7;
		logic [`EXEC_XLEN-1:0]     pc;
		logic [`EXEC_XLEN-1:0]     i_imm;
		logic [`EXEC_XLEN-1:0]     u_imm;
		logic [`EXEC_XLEN-1:0]     j_imm;
		logic [`EXEC_XLEN-1:0]     b_imm;
		logic                      src1_busy;
		logic [`EXEC_XLEN-1:0]     src1_val;
		logic                      src2_busy;
		logic [`EXEC_XLEN-1:0]     src2_val;
	} disp_t;

	// one waiting instruction, operation already decoded
	typedef struct packed {
		logic                      valid;
		logic [`EXEC_TAG_BITS-1:0] tag;
		alu_op_e                   alu_op;
		cmp_op_e                   cmp_op;
		logic                      use_cmp;
		logic                      op1_busy;
		logic [`EXEC_XLEN-1:0]     op1_val;
		logic                      op2_busy;
		logic [`EXEC_XLEN-1:0]     op2_val;
	} rs_entry_t;

	typedef struct packed {
		logic                      valid;
		logic [`EXEC_TAG_BITS-1:0] tag;
		logic [`EXEC_XLEN-1:0]     data;
	} bcast_t;

	typedef struct packed {
		logic [`EXEC_TAG_BITS-1:0] tag;
		logic [`EXEC_XLEN-1:0]     data;
		logic                      cmp_taken;
	} result_t;

	typedef struct packed {
		logic                      valid;
		logic [`EXEC_TAG_BITS-1:0] head_tag;
		logic [`EXEC_TAG_BITS-1:0] flush_tag;
	} flush_t;

	// live window runs from head_tag up to flush_tag, flush_tag excluded
	// equal tags mean an empty window
	function automatic logic tag_live(input logic [`EXEC_TAG_BITS-1:0] tag,
			input flush_t f);
		if (f.head_tag <= f.flush_tag) begin
			return (tag >= f.head_tag) && (tag < f.flush_tag);
		end
		// window wraps past the top tag
		return (tag >= f.head_tag) || (tag < f.flush_tag);
	endfunction

endpackage

`default_nettype wire

//--- rtl/reservation_station.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module reservation_station (
	input  logic                        clk,
	input  logic                        rst,
	input  exec_pkg::disp_t             disp,
	input  logic                        alloc_fire,
	input  exec_pkg::bcast_t            own_bcast,
	input  exec_pkg::bcast_t            ext_bcast,
	input  exec_pkg::flush_t            flush,
	input  logic                        issue_take,
	output exec_pkg::rs_entry_t         issue_entry,
	output logic                        issue_valid,
	output logic                        issue_fire,
	output logic [`EXEC_TAG_BITS-1:0]   kill_count
);

	localparam int IW = $clog2(`EXEC_ENTRIES);
	localparam int TW = `EXEC_TAG_BITS;

	exec_pkg::rs_entry_t entries     [`EXEC_ENTRIES];
	exec_pkg::rs_entry_t entries_nxt [`EXEC_ENTRIES];
	exec_pkg::rs_entry_t alloc_entry;
	logic [IW-1:0]       alloc_idx;
	logic [IW-1:0]       sel_idx;

	// operand snoop returning {busy, value}
	// a busy operand holds the producer tag in its low bits
	function automatic logic [`EXEC_XLEN:0] wake(input logic busy,
			input logic [`EXEC_XLEN-1:0] val,
			input exec_pkg::bcast_t own,
			input exec_pkg::bcast_t ext);
		logic [`EXEC_TAG_BITS-1:0] ptag;
		ptag = val[`EXEC_TAG_BITS-1:0];
		if (busy && own.valid && own.tag == ptag) begin
			return {1'b0, own.data};
		end
		if (busy && ext.valid && ext.tag == ptag) begin
			return {1'b0, ext.data};
		end
		return {busy, val};
	endfunction

	// opcode class picks alu or compare op and the operand sources
	function automatic exec_pkg::rs_entry_t decode(input exec_pkg::disp_t d);
		exec_pkg::rs_entry_t e;
		e.valid    = 1'b1;
		e.tag      = d.tag;
		e.alu_op   = exec_pkg::alu_op_e'(d.funct3);
		e.cmp_op   = exec_pkg::cmp_op_e'(d.funct3);
		e.use_cmp  = 1'b0;
		// register sources by default
		e.op1_busy = d.src1_busy;
		e.op1_val  = d.src1_val;
		e.op2_busy = d.src2_busy;
		e.op2_val  = d.src2_val;
		case (d.opcode)
			exec_pkg::op_jal: begin
				// jump target pc + j_imm
				e.alu_op   = exec_pkg::alu_add;
				e.op1_busy = 1'b0;
				e.op1_val  = d.pc;
				e.op2_busy = 1'b0;
				e.op2_val  = d.j_imm;
			end
			exec_pkg::op_jalr: begin
				e.alu_op   = exec_pkg::alu_add;
				e.op2_busy = 1'b0;
				e.op2_val  = d.i_imm;
			end
			exec_pkg::op_br: begin
				e.use_cmp = 1'b1;
			end
			exec_pkg::op_lui: begin
				e.alu_op   = exec_pkg::alu_add;
				e.op1_busy = 1'b0;
				e.op1_val  = d.u_imm;
				e.op2_busy = 1'b0;
				e.op2_val  = '0;
			end
			exec_pkg::op_auipc: begin
				e.alu_op   = exec_pkg::alu_add;
				e.op1_busy = 1'b0;
				e.op1_val  = d.pc;
				e.op2_busy = 1'b0;
				e.op2_val  = d.u_imm;
			end
			exec_pkg::op_reg, exec_pkg::op_imm: begin
				if (d.opcode == exec_pkg::op_imm) begin
					e.op2_busy = 1'b0;
					e.op2_val  = d.i_imm;
				end
				case (d.funct3)
					3'b000: begin
						// addi never subtracts
						if (d.opcode == exec_pkg::op_reg && d.funct7[5])
							e.alu_op = exec_pkg::alu_sub;
						else
							e.alu_op = exec_pkg::alu_add;
					end
					// slt and sltu go through the comparator
					3'b010: begin
						e.use_cmp = 1'b1;
						e.cmp_op  = exec_pkg::cmp_blt;
					end
					3'b011: begin
						e.use_cmp = 1'b1;
						e.cmp_op  = exec_pkg::cmp_bltu;
					end
					3'b101: begin
						e.alu_op = d.funct7[5] ? exec_pkg::alu_sra : exec_pkg::alu_srl;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
		return e;
	endfunction

	// new entry also snoops broadcasts of the dispatch cycle
	always_comb begin
		alloc_entry = decode(disp);
		{alloc_entry.op1_busy, alloc_entry.op1_val} =
			wake(alloc_entry.op1_busy, alloc_entry.op1_val, own_bcast, ext_bcast);
		{alloc_entry.op2_busy, alloc_entry.op2_val} =
			wake(alloc_entry.op2_busy, alloc_entry.op2_val, own_bcast, ext_bcast);
	end

	// lowest free slot and lowest ready slot
	// scanning downwards lets the low index win
	always_comb begin
		alloc_idx   = '0;
		sel_idx     = '0;
		issue_valid = 1'b0;
		for (int i = `EXEC_ENTRIES - 1; i >= 0; i--) begin
			if (!entries[i].valid)
				alloc_idx = IW'(i);
			if (entries[i].valid && !entries[i].op1_busy && !entries[i].op2_busy) begin
				sel_idx     = IW'(i);
				issue_valid = 1'b1;
			end
		end
	end

	assign issue_entry = entries[sel_idx];
	// flush cycle drops the issue
	assign issue_fire  = issue_valid && issue_take && !flush.valid;

	always_comb begin
		kill_count = '0;
		for (int i = 0; i < `EXEC_ENTRIES; i++) begin
			entries_nxt[i] = entries[i];
			{entries_nxt[i].op1_busy, entries_nxt[i].op1_val} =
				wake(entries[i].op1_busy, entries[i].op1_val, own_bcast, ext_bcast);
			{entries_nxt[i].op2_busy, entries_nxt[i].op2_val} =
				wake(entries[i].op2_busy, entries[i].op2_val, own_bcast, ext_bcast);
		end
		if (flush.valid) begin
			// squash everything outside the live window
			for (int i = 0; i < `EXEC_ENTRIES; i++) begin
				if (entries[i].valid && !exec_pkg::tag_live(entries[i].tag, flush)) begin
					entries_nxt[i].valid = 1'b0;
					kill_count = kill_count + TW'(1);
				end
			end
		end else begin
			if (issue_fire)
				entries_nxt[sel_idx].valid = 1'b0;
			// free slot never equals the issued one
			if (alloc_fire)
				entries_nxt[alloc_idx] = alloc_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `EXEC_ENTRIES; i++)
				entries[i].valid <= 1'b0;
		end else begin
			entries <= entries_nxt;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rs_free_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module rs_free_counter (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      alloc_fire,
	input  logic                      issue_fire,
	input  logic [`EXEC_TAG_BITS-1:0] kill_count,
	output logic                      disp_ready
);

	// wide enough to hold the full entry count
	localparam int CW = $clog2(`EXEC_ENTRIES + 1);

	logic [CW-1:0] free_cnt;
	logic [CW-1:0] free_nxt;

	always_comb begin
		// flushed entries come back in one step
		free_nxt = free_cnt + CW'(kill_count);
		if (alloc_fire)
			free_nxt = free_nxt - CW'(1);
		if (issue_fire)
			free_nxt = free_nxt + CW'(1);
	end

	always_ff @(posedge clk) begin
		if (rst)
			free_cnt <= CW'(`EXEC_ENTRIES);
		else
			free_cnt <= free_nxt;
	end

	assign disp_ready = (free_cnt != '0);

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module int_alu (
	input  exec_pkg::rs_entry_t entry,
	output exec_pkg::result_t   result
);

	logic [`EXEC_XLEN-1:0] a;
	logic [`EXEC_XLEN-1:0] b;
	logic [4:0]            shamt;
	logic [`EXEC_XLEN-1:0] alu_out;
	logic                  cmp_out;

	assign a     = entry.op1_val;
	assign b     = entry.op2_val;
	// rv32 shifts use the low five bits only
	assign shamt = b[4:0];

	always_comb begin
		case (entry.alu_op)
			exec_pkg::alu_add: alu_out = a + b;
			exec_pkg::alu_sll: alu_out = a << shamt;
			exec_pkg::alu_sra: alu_out = $unsigned($signed(a) >>> shamt);
			exec_pkg::alu_sub: alu_out = a - b;
			exec_pkg::alu_xor: alu_out = a ^ b;
			exec_pkg::alu_srl: alu_out = a >> shamt;
			exec_pkg::alu_or:  alu_out = a | b;
			exec_pkg::alu_and: alu_out = a & b;
			default:           alu_out = '0;
		endcase
	end

	always_comb begin
		case (entry.cmp_op)
			exec_pkg::cmp_beq:  cmp_out = (a == b);
			exec_pkg::cmp_bne:  cmp_out = (a != b);
			exec_pkg::cmp_blt:  cmp_out = ($signed(a) < $signed(b));
			exec_pkg::cmp_bge:  cmp_out = ($signed(a) >= $signed(b));
			exec_pkg::cmp_bltu: cmp_out = (a < b);
			exec_pkg::cmp_bgeu: cmp_out = (a >= b);
			// funct3 010/011 are not branches
			default:            cmp_out = 1'b0;
		endcase
	end

	// compare ops return the bit both as data (slt) and as taken (branch)
	assign result.tag       = entry.tag;
	assign result.data      = entry.use_cmp ? {{(`EXEC_XLEN - 1){1'b0}}, cmp_out} : alu_out;
	assign result.cmp_taken = entry.use_cmp && cmp_out;

endmodule

`default_nettype wire

//--- rtl/result_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module result_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue_valid,
	input  exec_pkg::result_t   alu_result,
	input  exec_pkg::flush_t    flush,
	input  logic                res_ready,
	output logic                issue_take,
	output exec_pkg::result_t   res,
	output logic                res_valid,
	output exec_pkg::bcast_t    own_bcast
);

	typedef enum logic {
		EMPTY = 1'b0,
		HELD  = 1'b1
	} state_e;

	state_e state;
	state_e state_nxt;
	logic   xfer;
	logic   load;

	assign res_valid  = (state == HELD);
	assign xfer       = res_valid && res_ready;
	// room when empty or when the held value leaves this cycle
	assign issue_take = (state == EMPTY) || res_ready;
	// no new result enters on a flush cycle
	assign load       = issue_valid && issue_take && !flush.valid;

	always_comb begin
		state_nxt = state;
		if (xfer)
			state_nxt = EMPTY;
		if (load)
			state_nxt = HELD;
		// held result outside the window is dropped
		if (flush.valid && state == HELD && !exec_pkg::tag_live(res.tag, flush))
			state_nxt = EMPTY;
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= EMPTY;
		else
			state <= state_nxt;
	end

	// payload only moves on load, stays put under back-pressure
	always_ff @(posedge clk) begin
		if (load)
			res <= alu_result;
	end

	// every accepted result doubles as the local wakeup broadcast
	assign own_bcast.valid = xfer;
	assign own_bcast.tag   = res.tag;
	assign own_bcast.data  = res.data;

endmodule

`default_nettype wire

//--- rtl/int_exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module int_exec_unit (
	input  logic              clk,
	input  logic              rst,
	input  exec_pkg::disp_t   disp,
	input  logic              disp_valid,
	output logic              disp_ready,
	input  exec_pkg::bcast_t  ext_bcast,
	input  exec_pkg::flush_t  flush,
	output exec_pkg::result_t res,
	output logic              res_valid,
	input  logic              res_ready
);

	exec_pkg::rs_entry_t       issue_entry;
	exec_pkg::result_t         alu_result;
	exec_pkg::bcast_t          own_bcast;
	logic                      issue_valid;
	logic                      issue_take;
	logic                      issue_fire;
	logic                      alloc_fire;
	logic [`EXEC_TAG_BITS-1:0] kill_count;

	// dispatch handshake, discarded when a flush lands in the same cycle
	assign alloc_fire = disp_valid && disp_ready && !flush.valid;

	reservation_station u_reservation_station (
		.clk         (clk),
		.rst         (rst),
		.disp        (disp),
		.alloc_fire  (alloc_fire),
		.own_bcast   (own_bcast),
		.ext_bcast   (ext_bcast),
		.flush       (flush),
		.issue_take  (issue_take),
		.issue_entry (issue_entry),
		.issue_valid (issue_valid),
		.issue_fire  (issue_fire),
		.kill_count  (kill_count)
	);

	rs_free_counter u_rs_free_counter (
		.clk        (clk),
		.rst        (rst),
		.alloc_fire (alloc_fire),
		.issue_fire (issue_fire),
		.kill_count (kill_count),
		.disp_ready (disp_ready)
	);

	int_alu u_int_alu (
		.entry  (issue_entry),
		.result (alu_result)
	);

	result_ctrl u_result_ctrl (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.alu_result  (alu_result),
		.flush       (flush),
		.res_ready   (res_ready),
		.issue_take  (issue_take),
		.res         (res),
		.res_valid   (res_valid),
		.own_bcast   (own_bcast)
	);

endmodule

`default_nettype wire

//--- tb/tb_int_exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module tb_int_exec_unit;

	localparam int N_BATCH = 40;
	// random batches of four plus one back-pressure group and one flush group
	localparam int N_DISP = N_BATCH * 4 + 8;
	localparam int LIMIT = N_DISP * 20 + 200;
	// tag owned by the other unit and never dispatched here
	localparam logic [2:0] EXT_TAG = 3'd7;

	logic clk;
	logic rst;
	logic disp_valid;
	logic disp_ready;
	logic res_valid;
	logic res_ready;
	exec_pkg::disp_t   disp;
	exec_pkg::bcast_t  ext_bcast;
	exec_pkg::flush_t  flush;
	exec_pkg::result_t res;

	logic [31:0] lfsr;
	logic [31:0] exp_data [8];
	logic        exp_taken [8];
	// outstanding when issued differs from done plus killed
	int          issue_cnt [8];
	int          kill_cnt [8];
	int          done_cnt [8];
	int          errors;
	int          results;
	int          cycles;
	logic [2:0]  next_tag;
	logic        rr_random;
	logic        solo;
	logic        solo_d1;
	logic        solo_d2;
	logic        hold_full;
	logic        exp_match;

	int_exec_unit u_int_exec_unit (
		.clk        (clk),
		.rst        (rst),
		.disp       (disp),
		.disp_valid (disp_valid),
		.disp_ready (disp_ready),
		.ext_bcast  (ext_bcast),
		.flush      (flush),
		.res        (res),
		.res_valid  (res_valid),
		.res_ready  (res_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		// galois form with taps for x^32 + x^22 + x^2 + x + 1
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic is_pending(input logic [2:0] t);
		return issue_cnt[t] != done_cnt[t] + kill_cnt[t];
	endfunction

	function automatic logic any_pending();
		for (int i = 0; i < 8; i++) begin
			if (is_pending(3'(i)))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// rv32i reference returning {taken, data}
	function automatic logic [32:0] model(input exec_pkg::disp_t d,
			input logic [31:0] r1, input logic [31:0] r2);
		logic [31:0] b;
		logic [31:0] v;
		logic        t;
		b = (d.opcode == exec_pkg::op_imm) ? d.i_imm : r2;
		t = 1'b0;
		v = '0;
		case (d.opcode)
			exec_pkg::op_lui:   v = d.u_imm;
			exec_pkg::op_auipc: v = d.pc + d.u_imm;
			exec_pkg::op_jal:   v = d.pc + d.j_imm;
			exec_pkg::op_jalr:  v = r1 + d.i_imm;
			exec_pkg::op_br: begin
				case (d.funct3)
					3'd0:    t = (r1 == r2);
					3'd1:    t = (r1 != r2);
					3'd4:    t = ($signed(r1) < $signed(r2));
					3'd5:    t = ($signed(r1) >= $signed(r2));
					3'd6:    t = (r1 < r2);
					default: t = (r1 >= r2);
				endcase
				v = {31'b0, t};
			end
			default: begin
				case (d.funct3)
					3'd0: v = (d.opcode == exec_pkg::op_reg && d.funct7[5]) ? r1 - b : r1 + b;
					3'd1: v = r1 << b[4:0];
					3'd2: t = ($signed(r1) < $signed(b));
					3'd3: t = (r1 < b);
					3'd4: v = r1 ^ b;
					3'd5: begin
						// arithmetic shift kept in its own signed expression
						if (d.funct7[5])
							v = $signed(r1) >>> b[4:0];
						else
							v = r1 >> b[4:0];
					end
					3'd6: v = r1 | b;
					default: v = r1 & b;
				endcase
				// slt and sltu report the bit as data and as taken
				if (d.funct3 == 3'd2 || d.funct3 == 3'd3)
					v = {31'b0, t};
			end
		endcase
		return {t, v};
	endfunction

	function automatic exec_pkg::opcode_e class_opcode(input logic [2:0] c);
		case (c)
			3'd0:    return exec_pkg::op_lui;
			3'd1:    return exec_pkg::op_auipc;
			3'd2:    return exec_pkg::op_jal;
			3'd3:    return exec_pkg::op_jalr;
			3'd4:    return exec_pkg::op_br;
			3'd5:    return exec_pkg::op_imm;
			default: return exec_pkg::op_reg;
		endcase
	endfunction

	// one cycle with inputs changing 1 ns after the edge
	task automatic tick();
		logic [31:0] r;
		@(posedge clk);
		#1;
		if (rr_random) begin
			get_bits(1, r);
			res_ready = r[0];
		end
	endtask

	task automatic send(input exec_pkg::disp_t d, input logic is_solo,
			input logic [31:0] r1, input logic [31:0] r2);
		logic [32:0] m;
		m = model(d, r1, r2);
		exp_data[d.tag]  = m[31:0];
		exp_taken[d.tag] = m[32];
		issue_cnt[d.tag] = issue_cnt[d.tag] + 1;
		disp       = d;
		disp_valid = 1'b1;
		solo       = is_solo;
		while (!disp_ready)
			tick();
		tick();
		disp_valid = 1'b0;
		solo       = 1'b0;
	endtask

	task automatic broadcast(input logic [2:0] t, input logic [31:0] v);
		ext_bcast.valid = 1'b1;
		ext_bcast.tag   = t;
		ext_bcast.data  = v;
		tick();
		ext_bcast.valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (any_pending())
			tick();
	endtask

	// source is a ready value, the previous tag or the external tag
	task automatic pick_src(input int k, input logic [2:0] prev_tag,
			input logic [31:0] prev_val, input logic [31:0] ext_val,
			output logic busy, output logic [31:0] field, output logic [31:0] val);
		logic [31:0] sel;
		get_bits(3, sel);
		busy = 1'b1;
		if (k > 0 && sel[2:0] < 3'd2) begin
			field = {29'b0, prev_tag};
			val   = prev_val;
		end else if (k > 0 && sel[2:0] == 3'd2) begin
			field = {29'b0, EXT_TAG};
			val   = ext_val;
		end else begin
			busy = 1'b0;
			get_bits(32, val);
			field = val;
		end
	endtask

	task automatic run_batch();
		exec_pkg::disp_t d;
		logic [31:0] ext_val;
		logic [31:0] prev_val;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] x;
		logic [2:0]  prev_tag;
		logic [32:0] m;
		prev_tag = 3'd0;
		prev_val = '0;
		get_bits(32, ext_val);
		for (int k = 0; k < 4; k++) begin
			d = '0;
			d.tag = next_tag;
			next_tag = (next_tag == 3'd6) ? 3'd0 : next_tag + 3'd1;
			get_bits(3, x);
			d.opcode = class_opcode(x[2:0]);
			get_bits(3, x);
			d.funct3 = x[2:0];
			if (d.opcode == exec_pkg::op_br && (x[2:0] == 3'd2 || x[2:0] == 3'd3))
				d.funct3 = {1'b1, x[1:0]};
			get_bits(1, x);
			d.funct7 = x[0] ? 7'h20 : 7'h00;
			get_bits(32, x);
			d.pc = {x[31:2], 2'b00};
			get_bits(32, d.i_imm);
			get_bits(32, d.u_imm);
			get_bits(32, d.j_imm);
			get_bits(32, d.b_imm);
			pick_src(k, prev_tag, prev_val, ext_val, d.src1_busy, d.src1_val, r1);
			pick_src(k, prev_tag, prev_val, ext_val, d.src2_busy, d.src2_val, r2);
			// equal operands now and then for beq and bge
			get_bits(2, x);
			if (!d.src1_busy && !d.src2_busy && x[1:0] == 2'd0) begin
				d.src2_val = d.src1_val;
				r2 = r1;
			end
			m = model(d, r1, r2);
			send(d, k == 0, r1, r2);
			prev_tag = d.tag;
			prev_val = m[31:0];
		end
		broadcast(EXT_TAG, ext_val);
		wait_idle();
	endtask

	// reg add whose src1 waits on the external tag when asked
	task automatic send_add(input logic [2:0] t, input logic busy1,
			input logic [31:0] a, input logic [31:0] b);
		exec_pkg::disp_t d;
		d = '0;
		d.tag       = t;
		d.opcode    = exec_pkg::op_reg;
		d.src1_busy = busy1;
		d.src1_val  = busy1 ? {29'b0, EXT_TAG} : a;
		d.src2_val  = b;
		send(d, 1'b0, a, b);
	endtask

	always_comb begin
		exp_match = is_pending(res.tag) && res.data == exp_data[res.tag]
			&& res.cmp_taken == exp_taken[res.tag];
	end

	always @(posedge clk) begin
		if (!rst && res_valid && res_ready) begin
			done_cnt[res.tag] <= done_cnt[res.tag] + 1;
			results <= results + 1;
		end
		solo_d1 <= disp_valid && disp_ready && solo;
		solo_d2 <= solo_d1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	a_reset: assert property (@(posedge clk) $fell(rst) |-> (!res_valid && disp_ready))
		else begin
			errors++;
			$display("FAILED %0t: wrong res_valid or disp_ready after reset", $time);
		end

	a_result: assert property (@(posedge clk) disable iff (rst)
		(res_valid && res_ready) |-> exp_match)
		else begin
			errors++;
			$display("FAILED %0t: tag %0d gave data %h taken %b", $time, res.tag,
				res.data, res.cmp_taken);
		end

	// res_valid rises exactly two cycles after the handshake
	a_latency: assert property (@(posedge clk) disable iff (rst)
		solo_d2 |-> (res_valid && !$past(res_valid)))
		else begin
			errors++;
			$display("FAILED %0t: res_valid not rising 2 cycles after dispatch", $time);
		end

	a_stable: assert property (@(posedge clk) disable iff (rst)
		(res_valid && !res_ready && !flush.valid) |=> (res_valid && $stable(res)))
		else begin
			errors++;
			$display("FAILED %0t: held result changed under back-pressure", $time);
		end

	a_full: assert property (@(posedge clk) disable iff (rst) hold_full |-> !disp_ready)
		else begin
			errors++;
			$display("FAILED %0t: disp_ready high with all entries in use", $time);
		end

	initial begin
		lfsr       = 32'hd788;
		rst        = 1'b1;
		disp       = '0;
		disp_valid = 1'b0;
		ext_bcast  = '0;
		flush      = '0;
		res_ready  = 1'b0;
		rr_random  = 1'b1;
		solo       = 1'b0;
		hold_full  = 1'b0;
		next_tag   = 3'd0;
		errors     = 0;
		results    = 0;
		cycles     = 0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		tick();
		for (int i = 0; i < N_BATCH; i++)
			run_batch();
		// fill all entries behind the external tag with the output stalled
		rr_random = 1'b0;
		res_ready = 1'b0;
		for (int i = 0; i < 4; i++)
			send_add(3'(i), 1'b1, 32'h1000, 32'(i * 3 + 1));
		hold_full = 1'b1;
		repeat (6) tick();
		hold_full = 1'b0;
		broadcast(EXT_TAG, 32'h1000);
		repeat (5) tick();
		rr_random = 1'b1;
		wait_idle();
		// wrapping window 6..0 keeps tags 6 and 0 and drops 1 and 2
		// tag 1 sits in the stalled result register when the flush hits
		rr_random = 1'b0;
		res_ready = 1'b0;
		send_add(3'd1, 1'b0, 32'h55, 32'h11);
		send_add(3'd6, 1'b1, 32'h2000, 32'h7);
		send_add(3'd0, 1'b1, 32'h2000, 32'h8);
		send_add(3'd2, 1'b1, 32'h2000, 32'h9);
		repeat (3) tick();
		kill_cnt[1] = kill_cnt[1] + 1;
		kill_cnt[2] = kill_cnt[2] + 1;
		flush.valid     = 1'b1;
		flush.head_tag  = 3'd6;
		flush.flush_tag = 3'd1;
		tick();
		flush.valid = 1'b0;
		broadcast(EXT_TAG, 32'h2000);
		rr_random = 1'b1;
		wait_idle();
		repeat (10) tick();
		$display("errors %0d, results %0d, cycles %0d", errors, results, cycles);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/reservation_station.sv
rtl/rs_free_counter.sv
rtl/int_alu.sv
rtl/result_ctrl.sv
rtl/int_exec_unit.sv
tb/tb_int_exec_unit.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sim.f --top-module tb_int_exec_unit -o sim_tb
	out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module tb_int_exec_unit

clean:
	rm -rf obj_dir
